// File: design/hamming_pkg.sv
// ====================
// Hamming code widths
// ====================

package hamming_pkg;

    // Smallest parity count that covers all data positions plus the no-error case
    function automatic int parity_bits(input int data_bits);
        int r;
        r = 1;
        while ((1 << r) < data_bits + r + 1) begin
            r++;
        end
        return r;
    endfunction

    // Decoded widths
    localparam int ENTRY_BITS = 11;
    localparam int MODE_BITS  = 5;

    // Codeword widths, 15 and 9
    localparam int DATA_CODE_BITS = ENTRY_BITS + parity_bits(ENTRY_BITS);
    localparam int MODE_CODE_BITS = MODE_BITS + parity_bits(MODE_BITS);

endpackage

// File: design/det_pkg.sv
// ====================
// Determinant types
// ====================

package det_pkg;

    // Matrix geometry
    localparam int MATRIX_DIM     = 4;
    localparam int MATRIX_ENTRIES = MATRIX_DIM * MATRIX_DIM;

    // Window counts for 2x2 and 3x3 sliding windows
    localparam int N_MINOR2 = (MATRIX_DIM - 1) * (MATRIX_DIM - 1);
    localparam int N_MINOR3 = (MATRIX_DIM - 2) * (MATRIX_DIM - 2);

    // Result widths
    localparam int MINOR2_BITS = 23;
    localparam int MINOR3_BITS = 51;
    localparam int RESULT_BITS = 207;

    typedef logic signed [hamming_pkg::ENTRY_BITS-1:0] entry_t;
    typedef logic signed [MINOR2_BITS-1:0]             minor2_t;
    typedef logic signed [MINOR3_BITS-1:0]             minor3_t;

    // Decoded mode, other codes are unsupported and give a zero result
    typedef enum logic [hamming_pkg::MODE_BITS-1:0] {
        MODE_MINOR2 = 4,
        MODE_MINOR3 = 6
    } mode_t;

    // ====================
    // Output word
    // ====================
    // Same 207 bits, read per mode
    // Window 0 always sits at the top
    typedef union packed {
        minor2_t [0:N_MINOR2-1] minor2;
        struct packed {
            logic [RESULT_BITS-N_MINOR3*MINOR3_BITS-1:0] pad;
            minor3_t [0:N_MINOR3-1]                      win;
        } minor3;
    } result_u;

endpackage

// File: design/hamming_decoder.sv
// ====================
// Hamming SEC decoder
// ====================

module hamming_decoder #(
    parameter int DATA_BITS = 11
) (
    input  logic [DATA_BITS+hamming_pkg::parity_bits(DATA_BITS)-1:0] code,
    output logic [DATA_BITS-1:0]                                     data
);

    localparam int PARITY_BITS = hamming_pkg::parity_bits(DATA_BITS);
    localparam int CODE_BITS   = DATA_BITS + PARITY_BITS;

    // Codeword position of the idx-th data bit, counting from the data MSB
    function automatic int data_pos(input int idx);
        int p;
        int seen;
        p = 0;
        seen = -1;
        while (seen < idx) begin
            p++;
            if ((p & (p - 1)) != 0) begin
                seen++;
            end
        end
        return p;
    endfunction

    logic [PARITY_BITS-1:0] syndrome;
    logic [CODE_BITS-1:0]   fixed;

    // Position 1 is the port MSB
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_BITS; p++) begin
            if (code[CODE_BITS-p]) begin
                syndrome = syndrome ^ PARITY_BITS'(p);
            end
        end
    end

    // Flip the bit the syndrome points at
    always_comb begin
        fixed = code;
        if (syndrome != '0 && syndrome <= CODE_BITS) begin
            fixed[CODE_BITS-syndrome] = ~code[CODE_BITS-syndrome];
        end
    end

    for (genvar i = 0; i < DATA_BITS; i++) begin : g_data
        assign data[DATA_BITS-1-i] = fixed[CODE_BITS-data_pos(i)];
    end

endmodule

// File: design/input_decoder.sv
// ====================
// Input decoder
// ====================

module input_decoder #(
    parameter int ENTRY_BITS = 11,
    parameter int MODE_BITS  = 5
) (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic                                                       in_valid,
    input  logic [ENTRY_BITS+hamming_pkg::parity_bits(ENTRY_BITS)-1:0] in_code,
    input  logic [MODE_BITS+hamming_pkg::parity_bits(MODE_BITS)-1:0]   mode_code,
    output logic                                                       entry_valid,
    output det_pkg::entry_t                                            entry,
    output logic                                                       mode_valid,
    output det_pkg::mode_t                                             mode
);

    logic [$bits(in_code)-1:0]   entry_code_q;
    logic [$bits(mode_code)-1:0] mode_code_q;
    logic                        in_burst;
    logic                        first_beat;
    logic [ENTRY_BITS-1:0]       entry_raw;
    logic [MODE_BITS-1:0]        mode_raw;

    // Mode only rides on the first beat of a burst
    assign first_beat = in_valid && !in_burst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_burst    <= 1'b0;
            entry_valid <= 1'b0;
            mode_valid  <= 1'b0;
        end else begin
            in_burst    <= in_valid;
            entry_valid <= in_valid;
            mode_valid  <= first_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            entry_code_q <= in_code;
        end
        if (first_beat) begin
            mode_code_q <= mode_code;
        end
    end

    // Decode after the register
    hamming_decoder #(.DATA_BITS(ENTRY_BITS)) i_entry_dec (
        .code (entry_code_q),
        .data (entry_raw)
    );

    hamming_decoder #(.DATA_BITS(MODE_BITS)) i_mode_dec (
        .code (mode_code_q),
        .data (mode_raw)
    );

    assign entry = det_pkg::entry_t'(entry_raw);
    assign mode  = det_pkg::mode_t'(mode_raw);

endmodule

// File: design/matrix_store.sv
// ====================
// Matrix store
// ====================

module matrix_store (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            entry_valid,
    input  det_pkg::entry_t entry,
    input  logic            store_release,
    output logic            matrix_full,
    output det_pkg::entry_t entries [det_pkg::MATRIX_ENTRIES]
);

    localparam int CNT_BITS = $clog2(det_pkg::MATRIX_ENTRIES);

    logic [CNT_BITS-1:0] fill_cnt;
    logic                write_en;
    logic                last_slot;

    // Entries arriving while full are dropped, contents stay put
    assign write_en  = entry_valid && !matrix_full;
    assign last_slot = (fill_cnt == CNT_BITS'(det_pkg::MATRIX_ENTRIES - 1));

    // ====================
    // Fill control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt    <= '0;
            matrix_full <= 1'b0;
        end else if (store_release) begin
            // Engine is done with this matrix
            fill_cnt    <= '0;
            matrix_full <= 1'b0;
        end else if (write_en) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (last_slot) begin
                matrix_full <= 1'b1;
            end
        end
    end

    // ====================
    // Entry storage
    // ====================
    // Row-major, slot index is {row, col}
    always_ff @(posedge clk) begin
        if (write_en) begin
            entries[fill_cnt] <= entry;
        end
    end

endmodule

// File: design/minor_engine.sv
// ====================
// Minor engine
// ====================

module minor_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mode_valid,
    input  det_pkg::mode_t   mode,
    input  logic             matrix_full,
    input  det_pkg::entry_t  entries [det_pkg::MATRIX_ENTRIES],
    output logic             store_release,
    output logic             out_valid,
    output det_pkg::result_u out_data
);

    det_pkg::mode_t   mode_q;
    logic [1:0]       outer;
    logic [1:0]       inner;
    logic             active;
    logic             last_step;
    logic [1:0]       row_t;
    logic [1:0]       row_b;
    logic [1:0]       col_l;
    logic [1:0]       col_r;
    logic [1:0]       edge_row;
    det_pkg::entry_t  e_tl;
    det_pkg::entry_t  e_tr;
    det_pkg::entry_t  e_bl;
    det_pkg::entry_t  e_br;
    det_pkg::entry_t  edge_l;
    det_pkg::entry_t  edge_r;
    det_pkg::minor2_t minor;
    det_pkg::minor3_t term_l;
    det_pkg::minor3_t term_r;
    logic [3:0]       slot;

    det_pkg::minor2_t [0:det_pkg::N_MINOR2-1] m2_q;
    det_pkg::minor3_t [0:det_pkg::N_MINOR3-1] m3_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= det_pkg::MODE_MINOR2;
        end else if (mode_valid) begin
            mode_q <= mode;
        end
    end

    // Matrix_full stays high through the out_valid cycle
    assign active        = matrix_full && !out_valid;
    assign store_release = out_valid;

    // Mode 4 walks 3x3 window corners, mode 6 walks 2 row pairs of 3 steps
    always_comb begin
        case (mode_q)
            det_pkg::MODE_MINOR2: last_step = (outer == 2'd2) && (inner == 2'd2);
            det_pkg::MODE_MINOR3: last_step = (outer == 2'd1) && (inner == 2'd2);
            default:              last_step = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outer     <= '0;
            inner     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= active && last_step;
            if (active) begin
                if (last_step) begin
                    outer <= '0;
                    inner <= '0;
                end else if (inner == 2'd2) begin
                    outer <= outer + 2'd1;
                    inner <= '0;
                end else begin
                    inner <= inner + 2'd1;
                end
            end
        end
    end

    // ====================
    // Window select
    // ====================
    // In mode 6 the minor drops row outer+inner and keeps the middle columns,
    // which both the left and right 3x3 windows share
    always_comb begin
        if (mode_q == det_pkg::MODE_MINOR3) begin
            row_t = (inner == 2'd0) ? outer + 2'd1 : outer;
            row_b = (inner == 2'd2) ? outer + 2'd1 : outer + 2'd2;
            col_l = 2'd1;
        end else begin
            row_t = outer;
            row_b = outer + 2'd1;
            col_l = inner;
        end
    end

    assign col_r    = col_l + 2'd1;
    assign edge_row = outer + inner;

    assign e_tl   = entries[{row_t, col_l}];
    assign e_tr   = entries[{row_t, col_r}];
    assign e_bl   = entries[{row_b, col_l}];
    assign e_br   = entries[{row_b, col_r}];
    assign edge_l = entries[{edge_row, 2'd0}];
    assign edge_r = entries[{edge_row, 2'd3}];

    // ====================
    // Arithmetic
    // ====================
    assign minor = det_pkg::minor2_t'(e_tl) * det_pkg::minor2_t'(e_br)
                 - det_pkg::minor2_t'(e_tr) * det_pkg::minor2_t'(e_bl);

    assign term_l = det_pkg::minor3_t'(minor) * det_pkg::minor3_t'(edge_l);
    assign term_r = det_pkg::minor3_t'(minor) * det_pkg::minor3_t'(edge_r);

    // Raster slot of the current 2x2 window
    assign slot = 4'(outer) * 4'd3 + 4'(inner);

    always_ff @(posedge clk) begin
        if (active) begin
            case (mode_q)
                det_pkg::MODE_MINOR2: m2_q[slot] <= minor;
                det_pkg::MODE_MINOR3: begin
                    // Cofactor signs go +, -, + down the edge columns
                    case (inner)
                        2'd0: begin
                            m3_q[{outer[0], 1'b0}] <= term_l;
                            m3_q[{outer[0], 1'b1}] <= term_r;
                        end
                        2'd1: begin
                            m3_q[{outer[0], 1'b0}] <= m3_q[{outer[0], 1'b0}] - term_l;
                            m3_q[{outer[0], 1'b1}] <= m3_q[{outer[0], 1'b1}] - term_r;
                        end
                        default: begin
                            m3_q[{outer[0], 1'b0}] <= m3_q[{outer[0], 1'b0}] + term_l;
                            m3_q[{outer[0], 1'b1}] <= m3_q[{outer[0], 1'b1}] + term_r;
                        end
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Zero unless presenting a result
    always_comb begin
        out_data = '0;
        if (out_valid) begin
            case (mode_q)
                det_pkg::MODE_MINOR2: out_data.minor2 = m2_q;
                det_pkg::MODE_MINOR3: out_data.minor3.win = m3_q;
                default:              out_data = '0;
            endcase
        end
    end

endmodule

// File: design/det_top.sv
// ====================
// Determinant top
// ====================

module det_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [hamming_pkg::DATA_CODE_BITS-1:0] in_code,
    input  logic [hamming_pkg::MODE_CODE_BITS-1:0] mode_code,
    output logic                                  out_valid,
    output det_pkg::result_u                      out_data
);

    logic            entry_valid;
    det_pkg::entry_t entry;
    logic            mode_valid;
    det_pkg::mode_t  mode;
    logic            matrix_full;
    det_pkg::entry_t entries [det_pkg::MATRIX_ENTRIES];
    logic            store_release;

    input_decoder #(
        .ENTRY_BITS (hamming_pkg::ENTRY_BITS),
        .MODE_BITS  (hamming_pkg::MODE_BITS)
    ) i_input_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_code     (in_code),
        .mode_code   (mode_code),
        .entry_valid (entry_valid),
        .entry       (entry),
        .mode_valid  (mode_valid),
        .mode        (mode)
    );

    matrix_store i_matrix_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .entry_valid   (entry_valid),
        .entry         (entry),
        .store_release (store_release),
        .matrix_full   (matrix_full),
        .entries       (entries)
    );

    minor_engine i_minor_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode_valid    (mode_valid),
        .mode          (mode),
        .matrix_full   (matrix_full),
        .entries       (entries),
        .store_release (store_release),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

// File: tb/det_checker.sv
// ====================
// Result checker
// ====================

module det_checker (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in_valid,
    input  logic [hamming_pkg::DATA_CODE_BITS-1:0] in_code,
    input  logic [hamming_pkg::MODE_CODE_BITS-1:0] mode_code,
    input  logic                                   out_valid,
    input  det_pkg::result_u                       out_data,
    output int                                     pass_count,
    output int                                     fail_count,
    output int                                     pending
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RES_BITS = det_pkg::RESULT_BITS;
    localparam int W2       = det_pkg::MINOR2_BITS;
    localparam int W3       = det_pkg::MINOR3_BITS;
    localparam int PAD      = RES_BITS - 4 * W3;
    localparam int DIM      = det_pkg::MATRIX_DIM;
    localparam int HALF     = 1 << (hamming_pkg::ENTRY_BITS - 1);
    localparam int SLOTS    = 256;

    int                  ent [16];
    int                  beat       = 0;
    logic                prev_valid = 1'b0;
    int                  cur_mode   = 0;
    int                  push_count = 0;
    int                  pop_count  = 0;
    int                  ok_count   = 0;
    int                  in_errors  = 0;
    int                  out_errors = 0;
    int                  slot;
    logic [RES_BITS-1:0] exp_mem [SLOTS];
    int                  mode_mem [SLOTS];

    assign pass_count = ok_count;
    assign fail_count = in_errors + out_errors;
    assign pending    = push_count - pop_count;

    // ====================
    // Reference model
    // ====================
    // Syndrome is the XOR of set-bit positions, position 1 at the MSB
    function automatic int hamming_fix(input logic [15:0] code, input int code_bits);
        logic [15:0] word;
        int          syn;
        int          data;
        word = code;
        syn  = 0;
        data = 0;
        for (int p = 1; p <= code_bits; p++) begin
            if (word[code_bits-p]) begin
                syn = syn ^ p;
            end
        end
        if (syn != 0 && syn <= code_bits) begin
            word[code_bits-syn] = ~word[code_bits-syn];
        end
        for (int p = 1; p <= code_bits; p++) begin
            if ((p & (p - 1)) != 0) begin
                data = (data << 1) | int'(word[code_bits-p]);
            end
        end
        return data;
    endfunction

    function automatic longint at(input int r, input int c);
        return longint'(ent[r*DIM+c]);
    endfunction

    function automatic longint det2(input longint a, input longint b,
                                    input longint c, input longint d);
        return a * d - b * c;
    endfunction

    // Expansion along the top row of the window
    function automatic longint det3_at(input int r, input int c);
        longint s;
        longint t;
        int     k0;
        int     k1;
        s = 0;
        for (int j = 0; j < 3; j++) begin
            k0 = (j == 0) ? c + 1 : c;
            k1 = (j == 2) ? c + 1 : c + 2;
            t  = at(r, c + j) * det2(at(r + 1, k0), at(r + 1, k1), at(r + 2, k0), at(r + 2, k1));
            s  = (j == 1) ? s - t : s + t;
        end
        return s;
    endfunction

    function automatic logic [RES_BITS-1:0] expected_result(input int mode);
        logic [RES_BITS-1:0] res;
        longint              d;
        res = '0;
        if (mode == int'(det_pkg::MODE_MINOR2)) begin
            for (int k = 0; k < 9; k++) begin
                d = det2(at(k / 3, k % 3), at(k / 3, k % 3 + 1),
                         at(k / 3 + 1, k % 3), at(k / 3 + 1, k % 3 + 1));
                res[RES_BITS-1-W2*k -: W2] = d[W2-1:0];
            end
        end else if (mode == int'(det_pkg::MODE_MINOR3)) begin
            for (int k = 0; k < 4; k++) begin
                d = det3_at(k / 2, k % 2);
                res[RES_BITS-1-PAD-W3*k -: W3] = d[W3-1:0];
            end
        end
        return res;
    endfunction

    // ====================
    // Input side
    // ====================
    always @(posedge clk) begin
        if (!rst_n) begin
            beat       = 0;
            prev_valid = 1'b0;
        end else begin
            if (in_valid && !prev_valid) begin
                if (pop_count != push_count) begin
                    $display("matrix %0d never produced out_valid before the next one started",
                             push_count - 1);
                    in_errors++;
                end
                cur_mode = hamming_fix(16'(mode_code), hamming_pkg::MODE_CODE_BITS);
                beat     = 0;
            end
            if (in_valid) begin
                ent[beat] = hamming_fix(16'(in_code), hamming_pkg::DATA_CODE_BITS);
                if (ent[beat] >= HALF) begin
                    ent[beat] = ent[beat] - 2 * HALF;
                end
                beat++;
                if (beat == 16) begin
                    exp_mem[push_count % SLOTS]  = expected_result(cur_mode);
                    mode_mem[push_count % SLOTS] = cur_mode;
                    push_count++;
                    beat = 0;
                end
            end
            prev_valid = in_valid;
        end
    end

    // ====================
    // Output side
    // ====================
    // Mid-cycle, outputs are settled
    always @(negedge clk) begin
        if (out_valid) begin
            if (pop_count == push_count) begin
                $display("out_valid at %0d ns with no complete matrix waiting for a result", $time);
                out_errors++;
            end else begin
                slot = (push_count - 1) % SLOTS;
                if (out_data !== exp_mem[slot]) begin
                    $display("[ERROR] %0d ns: matrix %0d mode %0d got %h expected %h", $time,
                             push_count - 1, mode_mem[slot], out_data, exp_mem[slot]);
                    $display("matrix %0d mode %0d: FAIL", push_count - 1, mode_mem[slot]);
                    out_errors++;
                end else begin
                    $display("matrix %0d mode %0d: pass", push_count - 1, mode_mem[slot]);
                    ok_count++;
                end
                pop_count = push_count;
            end
        end else if (out_data !== '0) begin
            $display("[ERROR] %0d ns: out_data is %h while out_valid is low", $time, out_data);
            out_errors++;
        end
    end

endmodule

// File: tb/det_tb.sv
// ====================
// Determinant testbench
// ====================

module det_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 16;
    localparam int SEED           = 32'h8f43;
    localparam int N_PER_GROUP    = 20;
    localparam int N_EDGE_CASE    = 8;
    localparam int N_ALTERNATE    = 12;
    localparam int N_MATRICES     = 3 * N_PER_GROUP + 2 * N_EDGE_CASE + N_ALTERNATE;
    localparam int TIMEOUT_CYCLES = N_MATRICES * 40 + 100;
    localparam int MAX_LATENCY    = 14;
    localparam int MODE_4         = int'(det_pkg::MODE_MINOR2);
    localparam int MODE_6         = int'(det_pkg::MODE_MINOR3);

    logic                                   clk;
    logic                                   rst_n;
    logic                                   in_valid;
    logic [hamming_pkg::DATA_CODE_BITS-1:0] in_code;
    logic [hamming_pkg::MODE_CODE_BITS-1:0] mode_code;
    logic                                   out_valid;
    det_pkg::result_u                       out_data;

    int pass_count;
    int fail_count;
    int pending;
    int stall_count;
    int sent_count;
    int mode_val;
    int matrix [16];

    det_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_code   (in_code),
        .mode_code (mode_code),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    det_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_code    (in_code),
        .mode_code  (mode_code),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Encoding helpers
    // ====================
    // Parity bits sit at power-of-two positions
    // Position 1 is the MSB
    function automatic logic [15:0] hamming_encode(input logic [15:0] data,
                                                   input int data_bits,
                                                   input int code_bits);
        logic [15:0] code;
        int          syn;
        int          i;
        code = '0;
        syn  = 0;
        i    = data_bits - 1;
        for (int p = 1; p <= code_bits; p++) begin
            if ((p & (p - 1)) != 0) begin
                code[code_bits-p] = data[i];
                if (data[i]) begin
                    syn = syn ^ p;
                end
                i--;
            end
        end
        for (int p = 1; p <= code_bits; p = p * 2) begin
            if ((syn & p) != 0) begin
                code[code_bits-p] = 1'b1;
            end
        end
        return code;
    endfunction

    // Zero or one flipped bit
    function automatic logic [15:0] maybe_flip(input logic [15:0] code,
                                               input int code_bits,
                                               input bit flip);
        logic [15:0] word;
        int          pos;
        word = code;
        if (flip && $urandom_range(0, 3) != 0) begin
            pos = int'($urandom_range(0, code_bits - 1));
            word[pos] = ~word[pos];
        end
        return word;
    endfunction

    task automatic random_fill();
        for (int k = 0; k < 16; k++) begin
            matrix[k] = int'($urandom_range(0, 2047)) - 1024;
        end
    endtask

    task automatic extreme_fill();
        for (int k = 0; k < 16; k++) begin
            matrix[k] = ($urandom_range(0, 1) != 0) ? 1023 : -1024;
        end
    endtask

    // One burst of 16 beats, then wait for the result and idle a while
    task automatic send_matrix(input int mode, input bit flip, input int idle);
        logic [15:0] mcode;
        logic [15:0] dcode;
        int          waited;
        mcode = hamming_encode(16'(mode), hamming_pkg::MODE_BITS, hamming_pkg::MODE_CODE_BITS);
        mcode = maybe_flip(mcode, hamming_pkg::MODE_CODE_BITS, flip);
        for (int k = 0; k < 16; k++) begin
            dcode = hamming_encode(16'(matrix[k] & 32'h7ff), hamming_pkg::ENTRY_BITS,
                                   hamming_pkg::DATA_CODE_BITS);
            dcode = maybe_flip(dcode, hamming_pkg::DATA_CODE_BITS, flip);
            @(negedge clk);
            in_valid  = 1'b1;
            in_code   = dcode[hamming_pkg::DATA_CODE_BITS-1:0];
            // Only the first beat carries the mode
            mode_code = (k == 0) ? mcode[hamming_pkg::MODE_CODE_BITS-1:0] : 9'($urandom);
        end
        @(negedge clk);
        in_valid  = 1'b0;
        in_code   = 15'($urandom);
        mode_code = 9'($urandom);
        sent_count++;
        waited = 0;
        while (!out_valid && waited < MAX_LATENCY) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("no out_valid within %0d cycles of the last beat of matrix %0d",
                     MAX_LATENCY, sent_count - 1);
            stall_count++;
        end
        repeat (idle) @(negedge clk);
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_code     = '0;
        mode_code   = '0;
        stall_count = 0;
        sent_count  = 0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Clean codes in each mode
        for (int n = 0; n < N_PER_GROUP; n++) begin
            random_fill();
            send_matrix(MODE_4, 1'b0, int'($urandom_range(1, 3)));
        end
        for (int n = 0; n < N_PER_GROUP; n++) begin
            random_fill();
            send_matrix(MODE_6, 1'b0, int'($urandom_range(1, 3)));
        end

        // Single-bit errors in entry and mode codes
        for (int n = 0; n < N_PER_GROUP; n++) begin
            random_fill();
            send_matrix((n % 2 == 0) ? MODE_4 : MODE_6, 1'b1, int'($urandom_range(1, 3)));
        end

        // Full-scale entries
        for (int n = 0; n < N_EDGE_CASE; n++) begin
            extreme_fill();
            send_matrix((n % 2 == 0) ? MODE_6 : MODE_4, 1'b0, int'($urandom_range(1, 3)));
        end

        // Unsupported modes starting with 22
        for (int n = 0; n < N_EDGE_CASE; n++) begin
            random_fill();
            mode_val = 22;
            if (n != 0) begin
                mode_val = MODE_4;
                while (mode_val == MODE_4 || mode_val == MODE_6) begin
                    mode_val = int'($urandom_range(0, 31));
                end
            end
            send_matrix(mode_val, 1'b1, int'($urandom_range(1, 3)));
        end

        // Back to back with alternating modes
        for (int n = 0; n < N_ALTERNATE; n++) begin
            random_fill();
            send_matrix((n % 2 == 0) ? MODE_4 : MODE_6, 1'b1, 1);
        end

        repeat (4) @(negedge clk);
        $display("matrices %0d, matched %0d, errors %0d, stalls %0d, unanswered %0d",
                 sent_count, pass_count, fail_count, stall_count, pending);
        if (fail_count == 0 && stall_count == 0 && pending == 0 && pass_count == sent_count) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

// File: files.f
design/hamming_pkg.sv
design/det_pkg.sv
design/hamming_decoder.sv
design/input_decoder.sv
design/matrix_store.sv
design/minor_engine.sv
design/det_top.sv
tb/det_checker.sv
tb/det_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the determinant testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module det_tb -f files.f -o det_sim

output=$(./obj_dir/det_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'all tests passed'; then
    exit 0
else
    exit 1
fi
